// File: bench/pmac_checks.svh
/* Compare tasks and result counters for the MAC lane testbench.
   Included inside pmac_tb; each check adds to the error count of the running test. */

int pass_count  = 0;
int fail_count  = 0;
int test_errors = 0;

// --------------------------------------------------
// Value and level compares
// --------------------------------------------------
// Dot-product result, shown in hex on a mismatch
task automatic check_value(
    input string                      sig,
    input logic [pmac_pkg::ACC_W-1:0] got,
    input logic [pmac_pkg::ACC_W-1:0] exp
);
    if (got !== exp) begin
        $display("[FAIL] %s: got 0x%09h, expected 0x%09h", sig, got, exp);
        test_errors++;
    end
endtask

// Single-bit strobes and levels such as done and busy
task automatic check_level(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h", sig, got, exp);
        test_errors++;
    end
endtask

// Protocol trouble that has no value to compare
task automatic report_problem(input string what);
    $display("Error: %s", what);
    test_errors++;
endtask

// --------------------------------------------------
// Per-test bookkeeping
// --------------------------------------------------
task automatic begin_test();
    test_errors = 0;
endtask

task automatic end_test(input string name);
    if (test_errors == 0) begin
        pass_count++;
        $display("[PASS] %s", name);
    end else begin
        fail_count++;
        $display("[FAIL] %s finished with %0d errors", name, test_errors);
    end
endtask

// File: bench/pmac_tb.sv
/* Testbench for the MAC lane. Runs a table of operand rows through pmac_top,
   checks each result against a reference dot product and counts the outcomes. */
`timescale 1ns/10ps

module pmac_tb;

    localparam int NROWS         = 9;
    localparam int NFIXED        = 5;
    localparam int RESET_CYCLES  = 4;
    // Worst case start to done is about 15 cycles
    localparam int DONE_WAIT     = 20;
    localparam int AFTER_DONE    = 3;
    localparam int BUSY_START_AT = 3;

    logic                         clk;
    logic                         rst_n;
    logic                         start;
    pmac_pkg::op_vec_t            a_vec;
    pmac_pkg::op_vec_t            v_vec;
    pmac_pkg::prec_vec_t          prec_vec;
    logic                         busy;
    logic                         done;
    logic [pmac_pkg::ACC_W-1:0]   result;

    // One stimulus row
    typedef struct packed {
        pmac_pkg::op_vec_t   a;
        pmac_pkg::op_vec_t   v;
        pmac_pkg::prec_vec_t p;
        logic                start_busy;
    } row_t;

    row_t   rows [NROWS];
    string  row_name [NROWS];
    integer seed = 62;

    `include "pmac_checks.svh"

    pmac_top pmac_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .a_vec    (a_vec),
        .v_vec    (v_vec),
        .prec_vec (prec_vec),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Backstop in case a row never completes
    initial begin
        repeat (NROWS * 20 + RESET_CYCLES) @(posedge clk);
        $display("Error: watchdog expired, the test sequence did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    // Mask both operands to the element precision, multiply, sum
    function automatic logic [pmac_pkg::ACC_W-1:0] model_dot(
        input pmac_pkg::op_vec_t   a,
        input pmac_pkg::op_vec_t   v,
        input pmac_pkg::prec_vec_t p
    );
        logic [pmac_pkg::ACC_W-1:0] sum;
        logic [15:0]                mask;
        sum = '0;
        for (int i = 0; i < pmac_pkg::LEN; i++) begin
            case (p[i])
                pmac_pkg::PREC_INT4: mask = 16'h000F;
                pmac_pkg::PREC_INT8: mask = 16'h00FF;
                default:             mask = 16'hFFFF;
            endcase
            sum = sum + pmac_pkg::ACC_W'(a[i] & mask) * pmac_pkg::ACC_W'(v[i] & mask);
        end
        return sum;
    endfunction

    // --------------------------------------------------
    // Stimulus table
    // --------------------------------------------------
    task automatic build_table();
        logic [31:0] rnd;
        for (int i = 0; i < pmac_pkg::LEN; i++) begin
            // All ones at INT4 so the upper bits must drop out
            rows[0].a[i] = 16'hFFFF;
            rows[0].v[i] = 16'hFFFF;
            rows[0].p[i] = pmac_pkg::PREC_INT4;
            // INT8 with junk in the upper byte
            rows[1].a[i] = 16'hC300 + 16'(i * 29 + 17);
            rows[1].v[i] = 16'h5A00 + 16'(255 - i * 31);
            rows[1].p[i] = pmac_pkg::PREC_INT8;
            // Maximal FULL16 products
            rows[2].a[i] = 16'hFFFF;
            rows[2].v[i] = 16'hFFFF;
            rows[2].p[i] = pmac_pkg::PREC_FULL16;
            rows[3].a[i] = 16'hF00D ^ 16'(i * 4369);
            rows[3].v[i] = 16'hBEEF - 16'(i * 777);
            rows[4].a[i] = 16'(i * 1000 + 123);
            rows[4].v[i] = 16'(40000 - i * 3000);
            rows[4].p[i] = (i % 2 == 0) ? pmac_pkg::PREC_FULL16 : pmac_pkg::PREC_INT8;
        end
        // Elements 0, 2 and 3 land on the three exits in the same cycle
        rows[3].p[0] = pmac_pkg::PREC_FULL16;
        rows[3].p[1] = pmac_pkg::PREC_FULL16;
        rows[3].p[2] = pmac_pkg::PREC_INT8;
        rows[3].p[3] = pmac_pkg::PREC_INT4;
        rows[3].p[4] = pmac_pkg::PREC_INT8;
        rows[3].p[5] = pmac_pkg::PREC_INT4;
        rows[3].p[6] = pmac_pkg::PREC_FULL16;
        rows[3].p[7] = pmac_pkg::PREC_INT4;
        row_name[0] = "int4_all_ones";
        row_name[1] = "int8_vectors";
        row_name[2] = "full16_max";
        row_name[3] = "mixed_same_cycle_exits";
        row_name[4] = "start_while_busy";
        for (int r = 0; r < NROWS; r++) begin
            rows[r].start_busy = (r == 4);
        end
        // Random rows with code 3 folded onto FULL16
        for (int r = NFIXED; r < NROWS; r++) begin
            for (int i = 0; i < pmac_pkg::LEN; i++) begin
                rnd = $random(seed);
                rows[r].a[i] = rnd[15:0];
                rows[r].v[i] = rnd[31:16];
                rnd = $random(seed);
                rows[r].p[i] = (rnd[1:0] == 2'd3) ? pmac_pkg::PREC_FULL16
                                                  : pmac_pkg::prec_t'(rnd[1:0]);
            end
            row_name[r] = $sformatf("random_%0d", r - NFIXED);
        end
    endtask

    // --------------------------------------------------
    // One row from start through done and the checks
    // --------------------------------------------------
    task automatic run_row(input int r);
        logic [pmac_pkg::ACC_W-1:0] expected;
        logic [pmac_pkg::ACC_W-1:0] got;
        pmac_pkg::prec_vec_t        all_full;
        int                         n_done;
        int                         cyc;
        begin_test();
        expected = model_dot(rows[r].a, rows[r].v, rows[r].p);
        got      = '0;
        n_done   = 0;
        cyc      = 0;
        for (int i = 0; i < pmac_pkg::LEN; i++) begin
            all_full[i] = pmac_pkg::PREC_FULL16;
        end
        @(posedge clk);
        a_vec    <= rows[r].a;
        v_vec    <= rows[r].v;
        prec_vec <= rows[r].p;
        start    <= 1'b1;
        while (n_done == 0 && cyc < DONE_WAIT) begin
            @(posedge clk);
            cyc++;
            if (rows[r].start_busy && cyc == BUSY_START_AT) begin
                // Second request mid-run that the lane must ignore
                a_vec    <= '1;
                v_vec    <= '1;
                prec_vec <= all_full;
                start    <= 1'b1;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            if (done) begin
                n_done++;
                got = result;
                check_level("busy", busy, 1'b0);
            end else begin
                // Held from the cycle after the accepted start
                check_level("busy", busy, 1'b1);
            end
        end
        if (n_done == 0) begin
            report_problem($sformatf("no done pulse within %0d cycles of start", DONE_WAIT));
        end else begin
            check_value("result", got, expected);
            // Result holds and no second done follows
            repeat (AFTER_DONE) begin
                @(negedge clk);
                if (done) begin
                    n_done++;
                end
                check_level("busy", busy, 1'b0);
                check_value("result", result, expected);
            end
            if (n_done > 1) begin
                report_problem($sformatf("%0d done pulses seen for one start", n_done));
            end
        end
        end_test(row_name[r]);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        rst_n    <= 1'b0;
        start    <= 1'b0;
        a_vec    <= '0;
        v_vec    <= '0;
        prec_vec <= '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        begin_test();
        @(negedge clk);
        check_level("done", done, 1'b0);
        check_level("busy", busy, 1'b0);
        check_value("result", result, '0);
        end_test("reset_state");
        for (int r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+bench
hdl/pmac_pkg.sv
hdl/pmac_issue.sv
hdl/pp_stage.sv
hdl/exit_merge.sv
hdl/dot_accum.sv
hdl/pmac_top.sv
bench/pmac_tb.sv

// File: hdl/dot_accum.sv
/* Dot-product accumulator. Adds each merged sum, counts retired items and pulses
   done when all LEN products are in; result holds until the next accepted start. */
`timescale 1ns/10ps

module dot_accum (
    input  logic                        clk,
    input  logic                        rst_n,
    input  pmac_pkg::merge_t            merged,
    input  logic                        start_accept,
    output logic                        done,
    output logic [pmac_pkg::ACC_W-1:0]  result
);

    logic [pmac_pkg::ACC_W-1:0]  acc_q;
    logic [pmac_pkg::CNT_W-1:0]  cnt_q;
    logic [pmac_pkg::CNT_W-1:0]  cnt_d;
    logic                        done_q;

    // Count after this cycle's retirements
    assign cnt_d = cnt_q + pmac_pkg::CNT_W'(merged.count);

    // --------------------------------------------------
    // Sum and retire count
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q  <= '0;
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else if (start_accept) begin
            // New vector pair, old result is dropped
            acc_q  <= '0;
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (merged.count != 2'd0) begin
                acc_q <= acc_q + pmac_pkg::ACC_W'(merged.sum);
                cnt_q <= cnt_d;
                // Single pulse, the count never passes LEN
                done_q <= (cnt_d == pmac_pkg::CNT_W'(pmac_pkg::LEN));
            end
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    // Result and done update on the same edge
    assign done   = done_q;
    assign result = acc_q;

endmodule

// File: hdl/exit_merge.sv
/* Merge stage at the three multiplier exits. Items that end at an exit matching
   their precision are summed and counted together in one registered step. */
`timescale 1ns/10ps

module exit_merge (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pmac_pkg::mul_item_t   exit4,
    input  pmac_pkg::mul_item_t   exit8,
    input  pmac_pkg::mul_item_t   exit16,
    output pmac_pkg::merge_t      merged
);

    logic                          hit4;
    logic                          hit8;
    logic                          hit16;
    logic [pmac_pkg::MSUM_W-1:0]   sum_d;
    logic [1:0]                    count_d;
    logic [pmac_pkg::MSUM_W-1:0]   sum_q;
    logic [1:0]                    count_q;

    // --------------------------------------------------
    // Exit selection
    // --------------------------------------------------
    // An item passing an exit at another precision is still in flight
    assign hit4  = exit4.valid  && (exit4.prec  == pmac_pkg::PREC_INT4);
    assign hit8  = exit8.valid  && (exit8.prec  == pmac_pkg::PREC_INT8);
    assign hit16 = exit16.valid && (exit16.prec == pmac_pkg::PREC_FULL16);

    // All three may land together, so every hit is added
    assign sum_d = (hit4  ? pmac_pkg::MSUM_W'(exit4.psum)  : '0)
                 + (hit8  ? pmac_pkg::MSUM_W'(exit8.psum)  : '0)
                 + (hit16 ? pmac_pkg::MSUM_W'(exit16.psum) : '0);

    assign count_d = {1'b0, hit4} + {1'b0, hit8} + {1'b0, hit16};

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= 2'd0;
        end else begin
            count_q <= count_d;
        end
    end

    always_ff @(posedge clk) begin
        sum_q <= sum_d;
    end

    assign merged = '{count: count_q, sum: sum_q};

endmodule

// File: hdl/pmac_issue.sv
/* Issue stage of the MAC lane. Captures the operand and precision vectors on an
   accepted start and sends one masked item per cycle into the multiplier chain. */
`timescale 1ns/10ps

module pmac_issue (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  pmac_pkg::op_vec_t     a_vec,
    input  pmac_pkg::op_vec_t     v_vec,
    input  pmac_pkg::prec_vec_t   prec_vec,
    input  logic                  retire_done,
    output logic                  busy,
    output logic                  start_accept,
    output pmac_pkg::mul_item_t   item
);

    pmac_pkg::issue_state_t        state;
    logic [pmac_pkg::IDX_W-1:0]    idx;
    logic                          busy_q;

    // Captured vectors
    pmac_pkg::op_vec_t             a_q;
    pmac_pkg::op_vec_t             v_q;
    pmac_pkg::prec_vec_t           prec_q;
    pmac_pkg::prec_t               cur_prec;

    // Keep only the low bits that the precision allows
    function automatic logic [pmac_pkg::DATA_W-1:0] mask_op(
        input logic [pmac_pkg::DATA_W-1:0] op,
        input pmac_pkg::prec_t             p
    );
        logic [pmac_pkg::DATA_W-1:0] m;
        case (p)
            pmac_pkg::PREC_INT4: m = (pmac_pkg::DATA_W'(1) << pmac_pkg::SLICE_W) - 1'b1;
            pmac_pkg::PREC_INT8: m = (pmac_pkg::DATA_W'(1) << (2 * pmac_pkg::SLICE_W)) - 1'b1;
            default:             m = '1;
        endcase
        return op & m;
    endfunction

    // Start only counts while the previous result has retired
    assign start_accept = start & ~busy;
    // Busy falls in the same cycle as done
    assign busy = busy_q & ~retire_done;

    // --------------------------------------------------
    // Issue FSM and element counter
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= pmac_pkg::IS_IDLE;
            idx    <= '0;
            busy_q <= 1'b0;
        end else begin
            if (start_accept) begin
                busy_q <= 1'b1;
            end else if (retire_done) begin
                busy_q <= 1'b0;
            end
            case (state)
                pmac_pkg::IS_IDLE: begin
                    if (start_accept) begin
                        state <= pmac_pkg::IS_RUN;
                        idx   <= '0;
                    end
                end
                pmac_pkg::IS_RUN: begin
                    idx <= idx + 1'b1;
                    // Last element leaves this cycle
                    if (idx == pmac_pkg::IDX_W'(pmac_pkg::LEN - 1)) begin
                        state <= pmac_pkg::IS_IDLE;
                    end
                end
                default: state <= pmac_pkg::IS_IDLE;
            endcase
        end
    end

    // Operand capture
    always_ff @(posedge clk) begin
        if (start_accept) begin
            a_q    <= a_vec;
            v_q    <= v_vec;
            prec_q <= prec_vec;
        end
    end

    // --------------------------------------------------
    // Item build for the current element
    // --------------------------------------------------
    always_comb begin
        // Undefined code runs as full width so it still retires
        case (prec_q[idx])
            pmac_pkg::PREC_INT4: cur_prec = pmac_pkg::PREC_INT4;
            pmac_pkg::PREC_INT8: cur_prec = pmac_pkg::PREC_INT8;
            default:             cur_prec = pmac_pkg::PREC_FULL16;
        endcase
        item.valid = (state == pmac_pkg::IS_RUN);
        item.prec  = cur_prec;
        item.a     = mask_op(a_q[idx], cur_prec);
        item.b_rem = mask_op(v_q[idx], cur_prec);
        item.psum  = '0;
    end

endmodule

// File: hdl/pmac_pkg.sv
/* Sizes, enums and pipeline structs shared by the precision-progressive MAC lane.
   RTL and testbench refer to everything here through pmac_pkg:: scoped names. */

package pmac_pkg;

    // --------------------------------------------------
    // Lane sizes
    // --------------------------------------------------
    localparam int DATA_W  = 16;
    localparam int LEN     = 8;
    localparam int SLICE_W = 4;
    localparam int PROD_W  = 32;
    // Eight maximal products need three guard bits
    localparam int ACC_W   = 35;
    localparam int IDX_W   = 3;
    // Merge sum holds up to three products at once
    localparam int MSUM_W  = 34;
    // Retired count must reach LEN itself
    localparam int CNT_W   = IDX_W + 1;

    // --------------------------------------------------
    // Enums
    // --------------------------------------------------
    // Code 2'd3 is not defined; issue treats it as full width
    typedef enum logic [1:0] {
        PREC_INT4   = 2'd0,
        PREC_INT8   = 2'd1,
        PREC_FULL16 = 2'd2
    } prec_t;

    typedef enum logic {
        IS_IDLE = 1'b0,
        IS_RUN  = 1'b1
    } issue_state_t;

    // Operand and precision vectors, element 0 in the low bits
    typedef logic [LEN-1:0][DATA_W-1:0] op_vec_t;
    typedef prec_t [LEN-1:0] prec_vec_t;

    // --------------------------------------------------
    // Pipeline structs
    // --------------------------------------------------
    // One multiply in flight, carrying its own precision
    typedef struct packed {
        logic              valid;
        prec_t             prec;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b_rem;
        logic [PROD_W-1:0] psum;
    } mul_item_t;

    // Products retired by the merge stage in one cycle
    typedef struct packed {
        logic [1:0]        count;
        logic [MSUM_W-1:0] sum;
    } merge_t;

endpackage

// File: hdl/pmac_top.sv
/* Top of the precision-progressive MAC lane. Wires issue, four multiplier
   stages, the exit merge and the accumulator into one pipeline. */
`timescale 1ns/10ps

module pmac_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  pmac_pkg::op_vec_t           a_vec,
    input  pmac_pkg::op_vec_t           v_vec,
    input  pmac_pkg::prec_vec_t         prec_vec,
    output logic                        busy,
    output logic                        done,
    output logic [pmac_pkg::ACC_W-1:0]  result
);

    // Item before stage 0 and after each of the four stages
    pmac_pkg::mul_item_t  stage_item [0:4];
    pmac_pkg::merge_t     merged;
    logic                 start_accept;

    // --------------------------------------------------
    // Issue
    // --------------------------------------------------
    pmac_issue issue_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .a_vec        (a_vec),
        .v_vec        (v_vec),
        .prec_vec     (prec_vec),
        .retire_done  (done),
        .busy         (busy),
        .start_accept (start_accept),
        .item         (stage_item[0])
    );

    // --------------------------------------------------
    // Shift-and-add multiplier, slice s of b per stage
    // --------------------------------------------------
    for (genvar s = 0; s < 4; s++) begin : g_stage
        pp_stage #(
            .SHIFT (s)
        ) stage_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .item_in  (stage_item[s]),
            .item_out (stage_item[s+1])
        );
    end

    // INT4 after stage 0, INT8 after stage 1, FULL16 after stage 3
    exit_merge merge_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .exit4  (stage_item[1]),
        .exit8  (stage_item[2]),
        .exit16 (stage_item[4]),
        .merged (merged)
    );

    dot_accum accum_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .merged       (merged),
        .start_accept (start_accept),
        .done         (done),
        .result       (result)
    );

endmodule

// File: hdl/pp_stage.sv
/* One stage of the shift-and-add multiplier. Adds a times the low slice of b_rem,
   placed at slice position SHIFT, into the running sum; four stages form a product. */
`timescale 1ns/10ps

module pp_stage #(
    parameter int SHIFT = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  pmac_pkg::mul_item_t   item_in,
    output pmac_pkg::mul_item_t   item_out
);

    // --------------------------------------------------
    // Slice partial product
    // --------------------------------------------------
    // x times a 4-bit slice, built from shifted copies of x
    function automatic logic [pmac_pkg::DATA_W+pmac_pkg::SLICE_W-1:0] slice_pp(
        input logic [pmac_pkg::DATA_W-1:0]  x,
        input logic [pmac_pkg::SLICE_W-1:0] y
    );
        logic [pmac_pkg::DATA_W+pmac_pkg::SLICE_W-1:0] acc;
        logic [pmac_pkg::DATA_W+pmac_pkg::SLICE_W-1:0] xw;
        acc = '0;
        xw  = {{pmac_pkg::SLICE_W{1'b0}}, x};
        for (int i = 0; i < pmac_pkg::SLICE_W; i++) begin
            if (y[i]) begin
                acc = acc + (xw << i);
            end
        end
        return acc;
    endfunction

    logic [pmac_pkg::DATA_W+pmac_pkg::SLICE_W-1:0] pp;
    logic [pmac_pkg::PROD_W-1:0]                   pp_placed;

    assign pp = slice_pp(item_in.a, item_in.b_rem[pmac_pkg::SLICE_W-1:0]);
    // Move to the weight of this slice within the product
    assign pp_placed = pmac_pkg::PROD_W'(pp) << (SHIFT * pmac_pkg::SLICE_W);

    // --------------------------------------------------
    // Stage registers
    // --------------------------------------------------
    logic                          valid_q;
    pmac_pkg::prec_t               prec_q;
    logic [pmac_pkg::DATA_W-1:0]   a_q;
    logic [pmac_pkg::DATA_W-1:0]   b_q;
    logic [pmac_pkg::PROD_W-1:0]   psum_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= item_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        prec_q <= item_in.prec;
        a_q    <= item_in.a;
        // Consumed slice drops out the bottom
        b_q    <= item_in.b_rem >> pmac_pkg::SLICE_W;
        psum_q <= item_in.psum + pp_placed;
    end

    assign item_out = '{
        valid: valid_q,
        prec:  prec_q,
        a:     a_q,
        b_rem: b_q,
        psum:  psum_q
    };

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the MAC lane testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -j 0 --top-module pmac_tb -Mdir obj_dir -f flist.f \
    > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vpmac_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$SIM_LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
